// ==== rtl/dp_consts.svh ====
`ifndef DP_CONSTS_SVH
`define DP_CONSTS_SVH

// ==================================================
// Datapath sizing
// ==================================================

// Word address width on the Wishbone side
`define DP_ADDR_W    16
// Data word width, buffer and bus
`define DP_DATA_W    32
// Buffer channels
`define DP_NUM_CH    4
// Words per channel segment, power of two
`define DP_SEG_DEPTH 16
// Beat and occupancy counters, holds 0 to DP_SEG_DEPTH
`define DP_BEATS_W   5

`endif

// ==== rtl/dp_pkg.sv ====
`include "dp_consts.svh"

package dp_pkg;

    // ==================================================
    // Scalar types
    // ==================================================

    // Channel number
    typedef logic [$clog2(`DP_NUM_CH)-1:0] ch_id_t;
    // Beat count of one command
    typedef logic [`DP_BEATS_W-1:0] beats_t;
    // Words held in one segment
    typedef logic [`DP_BEATS_W-1:0] seg_count_t;

    // ==================================================
    // Command and completion
    // ==================================================

    typedef struct packed {
        logic [`DP_ADDR_W-1:0] addr;
        beats_t                beats;
        ch_id_t                ch;
    } dp_cmd_t;

    // One-cycle completion report, beats counts acked beats only
    typedef struct packed {
        logic   strobe;
        logic   error;
        beats_t beats;
    } dp_done_t;

    // ==================================================
    // Wishbone classic
    // ==================================================

    // Master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`DP_ADDR_W-1:0] adr;
        logic [`DP_DATA_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [`DP_DATA_W-1:0] dat;
    } wb_rsp_t;

    // Engine FSM, shared by load and store
    typedef enum logic [1:0] {
        ENG_IDLE = 2'd0,
        ENG_BUS  = 2'd1,
        ENG_DONE = 2'd2
    } eng_state_e;

    // Bus owner
    typedef enum logic {
        OWN_LOAD  = 1'b0,
        OWN_STORE = 1'b1
    } arb_owner_e;

endpackage

// ==== rtl/seg_buffer.sv ====
`timescale 1ns/1ps
`include "dp_consts.svh"

module seg_buffer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 push,
    input  dp_pkg::ch_id_t                       push_ch,
    input  logic [`DP_DATA_W-1:0]                push_data,
    input  logic                                 pop,
    input  dp_pkg::ch_id_t                       pop_ch,
    output logic [`DP_DATA_W-1:0]                head_data,
    output dp_pkg::seg_count_t [`DP_NUM_CH-1:0]  counts
);
    import dp_pkg::*;

    localparam int PTR_W     = $clog2(`DP_SEG_DEPTH);
    localparam int MEM_DEPTH = `DP_NUM_CH * `DP_SEG_DEPTH;

    // ==================================================
    // Storage and ring state
    // ==================================================

    // One array, channel number in the upper address bits
    logic [`DP_DATA_W-1:0]          mem [MEM_DEPTH];
    logic [PTR_W-1:0]               wr_ptr [`DP_NUM_CH];
    logic [PTR_W-1:0]               rd_ptr [`DP_NUM_CH];
    seg_count_t [`DP_NUM_CH-1:0]    cnt_q;

    // Per-channel push and pop decode
    logic [`DP_NUM_CH-1:0]          push_hit;
    logic [`DP_NUM_CH-1:0]          pop_hit;

    always_comb begin
        for (int i = 0; i < `DP_NUM_CH; i++) begin
            push_hit[i] = push && (push_ch == ch_id_t'(i));
            pop_hit[i]  = pop && (pop_ch == ch_id_t'(i));
        end
    end

    // Write port, segment base plus ring pointer
    always_ff @(posedge clk) begin
        if (push) begin
            mem[{push_ch, wr_ptr[push_ch]}] <= push_data;
        end
    end

    // Head word of the popping channel, same cycle
    assign head_data = mem[{pop_ch, rd_ptr[pop_ch]}];

    // ==================================================
    // Pointers and occupancy
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DP_NUM_CH; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                cnt_q[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < `DP_NUM_CH; i++) begin
                // Pointers wrap inside the segment by overflow
                if (push_hit[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + PTR_W'(1);
                end
                if (pop_hit[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + PTR_W'(1);
                end
                // Push and pop together leave the count alone
                case ({push_hit[i], pop_hit[i]})
                    2'b10:   cnt_q[i] <= cnt_q[i] + seg_count_t'(1);
                    2'b01:   cnt_q[i] <= cnt_q[i] - seg_count_t'(1);
                    default: cnt_q[i] <= cnt_q[i];
                endcase
            end
        end
    end

    assign counts = cnt_q;

endmodule

// ==== rtl/load_engine.sv ====
`timescale 1ns/1ps
`include "dp_consts.svh"

module load_engine (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  dp_pkg::dp_cmd_t                      cmd,
    input  logic                                 cmd_valid,
    output logic                                 cmd_ready,
    input  dp_pkg::seg_count_t [`DP_NUM_CH-1:0]  counts,
    output dp_pkg::wb_req_t                      wb_req,
    input  dp_pkg::wb_rsp_t                      wb_rsp,
    output logic                                 push,
    output dp_pkg::ch_id_t                       push_ch,
    output logic [`DP_DATA_W-1:0]                push_data,
    output dp_pkg::dp_done_t                     done
);
    import dp_pkg::*;

    eng_state_e              state;
    logic [`DP_ADDR_W-1:0]   addr_q;
    beats_t                  beats_q;
    ch_id_t                  ch_q;
    beats_t                  cnt_q;
    logic                    err_q;
    // One idle cycle after each ack lets the arbiter switch owner
    logic                    gap_q;
    seg_count_t              free_space;
    logic                    accept;
    logic                    beat_req;
    logic                    beat_ack;
    logic                    beat_err;

    // Room left in the commanded segment
    assign free_space = seg_count_t'(`DP_SEG_DEPTH) - counts[cmd.ch];
    assign cmd_ready  = (state == ENG_IDLE) && (free_space >= cmd.beats);
    assign accept     = cmd_valid && cmd_ready;

    // Read beat held until ack or err
    assign beat_req   = (state == ENG_BUS) && !gap_q;
    assign wb_req.cyc = beat_req;
    assign wb_req.stb = beat_req;
    assign wb_req.we  = 1'b0;
    assign wb_req.adr = addr_q;
    assign wb_req.dat = '0;

    assign beat_ack = beat_req && wb_rsp.ack;
    assign beat_err = beat_req && wb_rsp.err;

    // Returned word goes straight into the segment
    assign push      = beat_ack;
    assign push_ch   = ch_q;
    assign push_data = wb_rsp.dat;

    assign done.strobe = (state == ENG_DONE);
    assign done.error  = err_q;
    assign done.beats  = cnt_q;

    // ==================================================
    // FSM
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENG_IDLE;
            cnt_q <= '0;
            err_q <= 1'b0;
            gap_q <= 1'b0;
        end else begin
            gap_q <= beat_ack;
            case (state)
                ENG_IDLE: begin
                    if (accept) begin
                        cnt_q <= '0;
                        err_q <= 1'b0;
                        // Empty command completes without bus traffic
                        state <= (cmd.beats == '0) ? ENG_DONE : ENG_BUS;
                    end
                end
                ENG_BUS: begin
                    if (beat_err) begin
                        err_q <= 1'b1;
                        state <= ENG_DONE;
                    end else if (beat_ack) begin
                        cnt_q <= cnt_q + beats_t'(1);
                        if (cnt_q + beats_t'(1) == beats_q) begin
                            state <= ENG_DONE;
                        end
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Command payload and running address
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= cmd.addr;
            beats_q <= cmd.beats;
            ch_q    <= cmd.ch;
        end else if (beat_ack) begin
            addr_q <= addr_q + `DP_ADDR_W'(1);
        end
    end

endmodule

// ==== rtl/store_engine.sv ====
`timescale 1ns/1ps
`include "dp_consts.svh"

module store_engine (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  dp_pkg::dp_cmd_t                      cmd,
    input  logic                                 cmd_valid,
    output logic                                 cmd_ready,
    input  dp_pkg::seg_count_t [`DP_NUM_CH-1:0]  counts,
    input  logic [`DP_DATA_W-1:0]                head_data,
    output logic                                 pop,
    output dp_pkg::ch_id_t                       pop_ch,
    output dp_pkg::wb_req_t                      wb_req,
    input  dp_pkg::wb_rsp_t                      wb_rsp,
    output dp_pkg::dp_done_t                     done
);
    import dp_pkg::*;

    eng_state_e              state;
    logic [`DP_ADDR_W-1:0]   addr_q;
    beats_t                  beats_q;
    ch_id_t                  ch_q;
    beats_t                  cnt_q;
    logic                    err_q;
    // Bus released for a cycle after every ack
    logic                    gap_q;
    logic                    accept;
    logic                    beat_req;
    logic                    beat_ack;
    logic                    beat_err;

    // Whole command must already sit in the segment
    assign cmd_ready = (state == ENG_IDLE) && (counts[cmd.ch] >= cmd.beats);
    assign accept    = cmd_valid && cmd_ready;

    // Write beat carries the head word of the latched channel
    assign beat_req   = (state == ENG_BUS) && !gap_q;
    assign wb_req.cyc = beat_req;
    assign wb_req.stb = beat_req;
    assign wb_req.we  = 1'b1;
    assign wb_req.adr = addr_q;
    assign wb_req.dat = head_data;

    assign beat_ack = beat_req && wb_rsp.ack;
    assign beat_err = beat_req && wb_rsp.err;

    // Head advances only once the slave took the word
    assign pop    = beat_ack;
    assign pop_ch = ch_q;

    assign done.strobe = (state == ENG_DONE);
    assign done.error  = err_q;
    assign done.beats  = cnt_q;

    // ==================================================
    // FSM
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENG_IDLE;
            cnt_q <= '0;
            err_q <= 1'b0;
            gap_q <= 1'b0;
        end else begin
            gap_q <= beat_ack;
            case (state)
                ENG_IDLE: begin
                    if (accept) begin
                        cnt_q <= '0;
                        err_q <= 1'b0;
                        state <= (cmd.beats == '0) ? ENG_DONE : ENG_BUS;
                    end
                end
                ENG_BUS: begin
                    // Error ends the command and leaves the word in the buffer
                    if (beat_err) begin
                        err_q <= 1'b1;
                        state <= ENG_DONE;
                    end else if (beat_ack) begin
                        cnt_q <= cnt_q + beats_t'(1);
                        if (cnt_q + beats_t'(1) == beats_q) begin
                            state <= ENG_DONE;
                        end
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Command payload and running address
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= cmd.addr;
            beats_q <= cmd.beats;
            ch_q    <= cmd.ch;
        end else if (beat_ack) begin
            addr_q <= addr_q + `DP_ADDR_W'(1);
        end
    end

endmodule

// ==== rtl/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  dp_pkg::wb_req_t   load_req,
    output dp_pkg::wb_rsp_t   load_rsp,
    input  dp_pkg::wb_req_t   store_req,
    output dp_pkg::wb_rsp_t   store_rsp,
    output dp_pkg::wb_req_t   bus_req,
    input  dp_pkg::wb_rsp_t   bus_rsp
);
    import dp_pkg::*;

    arb_owner_e  owner_q;
    arb_owner_e  owner;
    // Set when the store engine had the most recent beat
    logic        last_store_q;
    logic        owner_busy;

    // Grant moves only while the holder has cyc low
    always_comb begin
        owner_busy = (owner_q == OWN_LOAD) ? load_req.cyc : store_req.cyc;
        owner      = owner_q;
        if (!owner_busy) begin
            if (load_req.cyc && store_req.cyc) begin
                // Both asking, the one not served last wins
                owner = last_store_q ? OWN_LOAD : OWN_STORE;
            end else if (load_req.cyc) begin
                owner = OWN_LOAD;
            end else if (store_req.cyc) begin
                owner = OWN_STORE;
            end
        end
    end

    // Request mux, response back to the owner only
    assign bus_req   = (owner == OWN_LOAD) ? load_req : store_req;
    assign load_rsp  = (owner == OWN_LOAD) ? bus_rsp : '0;
    assign store_rsp = (owner == OWN_STORE) ? bus_rsp : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q      <= OWN_LOAD;
            last_store_q <= 1'b0;
        end else begin
            owner_q <= owner;
            // Round-robin history follows finished beats
            if (bus_req.cyc && (bus_rsp.ack || bus_rsp.err)) begin
                last_store_q <= (owner == OWN_STORE);
            end
        end
    end

endmodule

// ==== rtl/dp_top.sv ====
`timescale 1ns/1ps
`include "dp_consts.svh"

module dp_top (
    input  logic               clk,
    input  logic               rst_n,
    input  dp_pkg::dp_cmd_t    load_cmd,
    input  logic               load_valid,
    output logic               load_ready,
    output dp_pkg::dp_done_t   load_done,
    input  dp_pkg::dp_cmd_t    store_cmd,
    input  logic               store_valid,
    output logic               store_ready,
    output dp_pkg::dp_done_t   store_done,
    output dp_pkg::wb_req_t    wb_req,
    input  dp_pkg::wb_rsp_t    wb_rsp
);
    import dp_pkg::*;

    // ==================================================
    // Buffer side
    // ==================================================

    logic                           push;
    ch_id_t                         push_ch;
    logic [`DP_DATA_W-1:0]          push_data;
    logic                           pop;
    ch_id_t                         pop_ch;
    logic [`DP_DATA_W-1:0]          head_data;
    seg_count_t [`DP_NUM_CH-1:0]    counts;

    // Engine bus ports ahead of the arbiter
    wb_req_t  load_wb_req;
    wb_rsp_t  load_wb_rsp;
    wb_req_t  store_wb_req;
    wb_rsp_t  store_wb_rsp;

    seg_buffer u_seg_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_ch   (push_ch),
        .push_data (push_data),
        .pop       (pop),
        .pop_ch    (pop_ch),
        .head_data (head_data),
        .counts    (counts)
    );

    // Memory to buffer
    load_engine u_load_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (load_cmd),
        .cmd_valid (load_valid),
        .cmd_ready (load_ready),
        .counts    (counts),
        .wb_req    (load_wb_req),
        .wb_rsp    (load_wb_rsp),
        .push      (push),
        .push_ch   (push_ch),
        .push_data (push_data),
        .done      (load_done)
    );

    // Buffer to memory
    store_engine u_store_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (store_cmd),
        .cmd_valid (store_valid),
        .cmd_ready (store_ready),
        .counts    (counts),
        .head_data (head_data),
        .pop       (pop),
        .pop_ch    (pop_ch),
        .wb_req    (store_wb_req),
        .wb_rsp    (store_wb_rsp),
        .done      (store_done)
    );

    // ==================================================
    // Shared Wishbone master
    // ==================================================

    wb_arbiter u_wb_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_wb_req),
        .load_rsp  (load_wb_rsp),
        .store_req (store_wb_req),
        .store_rsp (store_wb_rsp),
        .bus_req   (wb_req),
        .bus_rsp   (wb_rsp)
    );

endmodule

// ==== tests/wb_mem_model.sv ====
`timescale 1ns/1ps
`include "dp_consts.svh"

module wb_mem_model #(
    parameter logic [`DP_ADDR_W-1:0] ERR_BASE = 16'hF000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  dp_pkg::wb_req_t  req,
    output dp_pkg::wb_rsp_t  rsp
);
    import dp_pkg::*;

    localparam int WORDS = 1 << `DP_ADDR_W;

    logic [`DP_DATA_W-1:0] mem [WORDS];
    integer                seed;
    // Wait states still to insert before the current beat answers
    int unsigned           wait_left;

    // Preset contents, both halves follow the full address
    function automatic logic [`DP_DATA_W-1:0] fill_word(input logic [`DP_ADDR_W-1:0] a);
        return {a ^ 16'hc3a5, a + 16'h1357};
    endfunction

    initial begin
        seed = 72892;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = fill_word(`DP_ADDR_W'(i));
        end
    end

    // ==================================================
    // Classic slave, one registered ack or err per beat
    // ==================================================

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp       <= '0;
            wait_left = 0;
        end else begin
            rsp.ack <= 1'b0;
            rsp.err <= 1'b0;
            // Skip the cycle where the previous answer is still visible
            if (req.cyc && req.stb && !rsp.ack && !rsp.err) begin
                if (wait_left != 0) begin
                    wait_left = wait_left - 1;
                end else begin
                    // Stretch of the next beat, 0 to 3 cycles
                    wait_left = $unsigned($random(seed)) % 4;
                    if (req.adr >= ERR_BASE) begin
                        rsp.err <= 1'b1;
                    end else begin
                        rsp.ack <= 1'b1;
                        if (req.we) begin
                            mem[req.adr] = req.dat;
                        end else begin
                            rsp.dat <= mem[req.adr];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== tests/tb_dp_top.sv ====
`timescale 1ns/1ps
`include "dp_consts.svh"

module tb_dp_top;
    import dp_pkg::*;

    localparam int KIND_LOAD     = 0;
    localparam int KIND_STORE    = 1;
    localparam int HOLD_CYCLES   = 40;
    localparam int GROUP_TIMEOUT = 2000;
    localparam logic [`DP_ADDR_W-1:0] ERR_BASE = 16'hF000;

    // One command with its expected completion
    typedef struct {
        int                    kind;
        int                    ch;
        logic [`DP_ADDR_W-1:0] addr;
        int                    beats;
        int                    exp_err;
        int                    exp_beats;
        // Issued in the same cycle as the next row
        int                    together;
        // Must be refused for HOLD_CYCLES before its partner starts
        int                    hold;
    } row_t;

    logic     clk;
    logic     rst_n;
    dp_cmd_t  load_cmd;
    logic     load_valid;
    logic     load_ready;
    dp_done_t load_done;
    dp_cmd_t  store_cmd;
    logic     store_valid;
    logic     store_ready;
    dp_done_t store_done;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;

    row_t                  tbl [$];
    // Expected segment contents, head first
    logic [`DP_DATA_W-1:0] chq [`DP_NUM_CH][$];

    dp_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_cmd    (load_cmd),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_done   (load_done),
        .store_cmd   (store_cmd),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_done  (store_done),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp)
    );

    wb_mem_model #(.ERR_BASE(ERR_BASE)) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (wb_req),
        .rsp   (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // Helpers and checks
    // ==================================================

    // Expected memory contents before any store
    function automatic logic [`DP_DATA_W-1:0] source_word(input logic [`DP_ADDR_W-1:0] a);
        return {a ^ 16'hc3a5, a + 16'h1357};
    endfunction

    function automatic logic ready_of(input int k);
        return (k == KIND_LOAD) ? load_ready : store_ready;
    endfunction

    function automatic dp_done_t done_of(input int k);
        return (k == KIND_LOAD) ? load_done : store_done;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [`DP_DATA_W-1:0] got,
                              input logic [`DP_DATA_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_done(input string name, input dp_done_t got, input int exp_err,
                              input int exp_beats);
        dp_done_t exp;
        exp.strobe = 1'b1;
        exp.error  = (exp_err != 0);
        exp.beats  = beats_t'(exp_beats);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic add_row(input int kind, input int ch, input logic [`DP_ADDR_W-1:0] addr,
                           input int beats, input int exp_err, input int exp_beats,
                           input int together, input int hold);
        row_t r;
        r = '{kind, ch, addr, beats, exp_err, exp_beats, together, hold};
        tbl.push_back(r);
    endtask

    task automatic build_table();
        // Copy one run through channel 1
        add_row(KIND_LOAD,  1, 16'h0100, 8, 0, 8, 0, 0);
        add_row(KIND_STORE, 1, 16'h8000, 8, 0, 8, 0, 0);
        // Channels 0 and 2 filled alternately, drained one by one
        add_row(KIND_LOAD,  0, 16'h0200, 4, 0, 4, 0, 0);
        add_row(KIND_LOAD,  2, 16'h0300, 4, 0, 4, 0, 0);
        add_row(KIND_LOAD,  0, 16'h0210, 4, 0, 4, 0, 0);
        add_row(KIND_LOAD,  2, 16'h0310, 5, 0, 5, 0, 0);
        add_row(KIND_STORE, 0, 16'h8100, 8, 0, 8, 0, 0);
        add_row(KIND_STORE, 2, 16'h8200, 9, 0, 9, 0, 0);
        // Store on an empty segment waits for the load behind it
        add_row(KIND_STORE, 3, 16'h8300, 6, 0, 6, 1, 1);
        add_row(KIND_LOAD,  3, 16'h0400, 6, 0, 6, 0, 0);
        // Full segment, load waits until the store frees room
        add_row(KIND_LOAD,  3, 16'h0500, 16, 0, 16, 0, 0);
        add_row(KIND_LOAD,  3, 16'h0600, 4, 0, 4, 1, 1);
        add_row(KIND_STORE, 3, 16'h8400, 8, 0, 8, 0, 0);
        add_row(KIND_STORE, 3, 16'h8500, 12, 0, 12, 0, 0);
        // Load and store side by side on the shared bus
        add_row(KIND_LOAD,  2, 16'h0800, 7, 0, 7, 0, 0);
        add_row(KIND_LOAD,  1, 16'h0700, 10, 0, 10, 1, 0);
        add_row(KIND_STORE, 2, 16'h8600, 7, 0, 7, 0, 0);
        add_row(KIND_STORE, 1, 16'h8700, 10, 0, 10, 0, 0);
        // Read run crossing ERR_BASE, only 4 words below it
        add_row(KIND_LOAD,  0, 16'hEFFC, 8, 1, 4, 0, 0);
        add_row(KIND_STORE, 0, 16'h8800, 4, 0, 4, 0, 0);
    endtask

    task automatic present_cmd(input int k, input row_t r);
        dp_cmd_t c;
        c.addr  = r.addr;
        c.beats = beats_t'(r.beats);
        c.ch    = ch_id_t'(r.ch);
        if (k == KIND_LOAD) begin
            load_cmd   <= c;
            load_valid <= 1'b1;
        end else begin
            store_cmd   <= c;
            store_valid <= 1'b1;
        end
    endtask

    // ==================================================
    // One group of rows, up to one per port
    // ==================================================

    task automatic run_group(input int first, input int n);
        int       row_of [2];
        bit       presented [2];
        bit       taken [2];
        bit       finished [2];
        int       held;
        int       cycles;
        dp_done_t got;
        row_of[0] = -1;
        row_of[1] = -1;
        for (int k = 0; k < 2; k++) begin
            presented[k] = 1'b0;
            taken[k]     = 1'b0;
            finished[k]  = 1'b0;
        end
        for (int j = first; j < first + n; j++) begin
            row_of[tbl[j].kind] = j;
        end
        held   = (n > 1 && tbl[first].hold != 0) ? tbl[first].kind : -1;
        cycles = 0;
        while (!((row_of[0] < 0 || finished[0]) && (row_of[1] < 0 || finished[1]))) begin
            @(posedge clk);
            for (int k = 0; k < 2; k++) begin
                if (taken[k]) begin
                    if (k == KIND_LOAD) begin
                        load_valid <= 1'b0;
                    end else begin
                        store_valid <= 1'b0;
                    end
                end else if (row_of[k] >= 0 && !presented[k] &&
                             (held < 0 || held == k || cycles >= HOLD_CYCLES)) begin
                    present_cmd(k, tbl[row_of[k]]);
                    presented[k] = 1'b1;
                end
            end
            // Stable half of the cycle
            @(negedge clk);
            cycles++;
            for (int k = 0; k < 2; k++) begin
                if (presented[k] && !taken[k] && ready_of(k)) begin
                    if (k == held && cycles <= HOLD_CYCLES) begin
                        report_failure($sformatf("Row %0d was accepted although its segment %s",
                                                 row_of[k], "could not cover the beats yet"));
                    end
                    taken[k] = 1'b1;
                end
                got = done_of(k);
                if (got.strobe) begin
                    if (row_of[k] < 0 || !taken[k] || finished[k]) begin
                        report_failure($sformatf("Done strobe on port %0d with no command open", k));
                    end else begin
                        check_done((k == KIND_LOAD) ? "load_done" : "store_done", got,
                                   tbl[row_of[k]].exp_err, tbl[row_of[k]].exp_beats);
                        finished[k] = 1'b1;
                    end
                end
            end
            if (cycles > GROUP_TIMEOUT) begin
                report_failure($sformatf("Commands from row %0d never completed", first));
            end
        end
    endtask

    // Loads append before stores drain, stored words go to memory in order
    task automatic update_model(input int first, input int n);
        logic [`DP_ADDR_W-1:0] a;
        logic [`DP_DATA_W-1:0] exp_w;
        for (int j = first; j < first + n; j++) begin
            if (tbl[j].kind == KIND_LOAD) begin
                for (int b = 0; b < tbl[j].exp_beats; b++) begin
                    a = tbl[j].addr + `DP_ADDR_W'(b);
                    chq[tbl[j].ch].push_back(source_word(a));
                end
            end
        end
        for (int j = first; j < first + n; j++) begin
            if (tbl[j].kind == KIND_STORE) begin
                for (int b = 0; b < tbl[j].exp_beats; b++) begin
                    if (chq[tbl[j].ch].size() == 0) begin
                        report_failure($sformatf("Row %0d stores more words than were loaded", j));
                    end
                    a     = tbl[j].addr + `DP_ADDR_W'(b);
                    exp_w = chq[tbl[j].ch].pop_front();
                    check_word($sformatf("mem[%h]", a), u_mem.mem[a], exp_w);
                end
            end
        end
    endtask

    // ==================================================
    // Sequence
    // ==================================================

    initial begin
        int      first;
        int      n;
        int      leftover;
        dp_cmd_t probe;
        rst_n       = 1'b0;
        load_valid  = 1'b0;
        store_valid = 1'b0;
        load_cmd    = '0;
        store_cmd   = '0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet bus and empty segments after reset
        for (int c = 0; c < `DP_NUM_CH; c++) begin
            @(posedge clk);
            probe.addr  = '0;
            probe.beats = beats_t'(1);
            probe.ch    = ch_id_t'(c);
            store_cmd <= probe;
            @(negedge clk);
            check_bit($sformatf("store_ready[ch%0d]", c), store_ready, 1'b0);
            check_bit("wb_req.cyc", wb_req.cyc, 1'b0);
            check_bit("load_done.strobe", load_done.strobe, 1'b0);
            check_bit("store_done.strobe", store_done.strobe, 1'b0);
        end

        first = 0;
        while (first < tbl.size()) begin
            n = (tbl[first].together != 0 && first + 1 < tbl.size()) ? 2 : 1;
            run_group(first, n);
            update_model(first, n);
            first += n;
        end

        leftover = 0;
        for (int c = 0; c < `DP_NUM_CH; c++) begin
            leftover += chq[c].size();
        end
        if (leftover == 0 && wb_req.cyc == 1'b0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure($sformatf("%0d words left in the segments or bus still busy", leftover));
        end
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/dp_pkg.sv
rtl/seg_buffer.sv
rtl/load_engine.sv
rtl/store_engine.sv
rtl/wb_arbiter.sv
rtl/dp_top.sv
tests/wb_mem_model.sv
tests/tb_dp_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module tb_dp_top -o tb_dp_top > compile.log 2>&1
if [ $? -ne 0 ]; then
    cat compile.log
    echo "Compile failed"
    exit 1
fi

./obj_dir/tb_dp_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** TEST PASSED ***' sim.log; then
    exit 0
fi
exit 1
